/* hdl/bridgePkg.sv */
package bridgePkg;

	// AHB transfer types.
	localparam logic [1:0] transIdle = 2'b00;
	localparam logic [1:0] transBusy = 2'b01;
	localparam logic [1:0] transNonseq = 2'b10;
	localparam logic [1:0] transSeq = 2'b11;

	localparam logic [1:0] respOkay = 2'b00;

	// three 64 MB windows, picked by the top address bits.
	localparam int windowBits = 6;
	localparam logic [31:0] slaveBase0 = 32'h8000_0000;
	localparam logic [31:0] slaveBase1 = 32'h8400_0000;
	localparam logic [31:0] slaveBase2 = 32'h8800_0000;

	// one-hot peripheral selects.
	localparam logic [2:0] selNone = 3'b000;
	localparam logic [2:0] sel0 = 3'b001;
	localparam logic [2:0] sel1 = 3'b010;
	localparam logic [2:0] sel2 = 3'b100;

	typedef enum logic [2:0]
	{
		stIdle = 3'b000,
		stWwait = 3'b001,
		stRead = 3'b010,
		stWrite = 3'b011,
		stWriteP = 3'b100, // write setup with another phase pending.
		stRenable = 3'b101,
		stWenable = 3'b110,
		stWenableP = 3'b111
	} apbState_t;

endpackage

/* hdl/ahbPipeIf.sv */
`timescale 1ns/1ps

interface ahbPipeIf;

	logic valid; // good address phase on the bus now.
	logic [31:0] Haddr1;
	logic [31:0] Haddr2;
	logic [31:0] Hwdata1;
	logic [31:0] Hwdata2;
	logic Hwritereg; // direction of the last valid phase.
	logic [2:0] tempselx;

	modport front
	(
		output valid,
		output Haddr1,
		output Haddr2,
		output Hwdata1,
		output Hwdata2,
		output Hwritereg,
		output tempselx
	);

	modport ctrl
	(
		input valid,
		input Haddr1,
		input Haddr2,
		input Hwdata1,
		input Hwdata2,
		input Hwritereg,
		input tempselx
	);

endinterface

/* hdl/ahbSlaveFront.sv */
`timescale 1ns/1ps

module ahbSlaveFront
	import bridgePkg::*;
(
	input logic Hclk,
	input logic Hresetn,
	input logic Hreadyin,
	input logic [1:0] Htrans,
	input logic Hwrite,
	input logic [31:0] Haddr,
	input logic [31:0] Hwdata,
	ahbPipeIf.front pipe
);

	logic inWindow0;
	logic inWindow1;
	logic inWindow2;
	logic active;
	logic [2:0] winSel;

	// compare only the window bits.
	assign inWindow0 = Haddr[31 -: windowBits] == slaveBase0[31 -: windowBits];
	assign inWindow1 = Haddr[31 -: windowBits] == slaveBase1[31 -: windowBits];
	assign inWindow2 = Haddr[31 -: windowBits] == slaveBase2[31 -: windowBits];

	always_comb
	begin
		if (inWindow0)
			winSel = sel0;
		else if (inWindow1)
			winSel = sel1;
		else if (inWindow2)
			winSel = sel2;
		else
			winSel = selNone;
	end

	// busy and idle carry no transfer.
	always_comb
	begin
		case (Htrans)
			transNonseq, transSeq:
				active = 1'b1;
			transIdle, transBusy:
				active = 1'b0;
			default:
				active = 1'b0;
		endcase
	end

	assign pipe.tempselx = winSel;
	assign pipe.valid = Hreadyin && active && (winSel != selNone);

	// address and data pipeline.
	always_ff @(posedge Hclk)
	begin
		pipe.Haddr1 <= Haddr;
		pipe.Haddr2 <= pipe.Haddr1;
		pipe.Hwdata1 <= Hwdata;
		pipe.Hwdata2 <= pipe.Hwdata1;
	end

	// only a valid phase updates the write flag, so a stalled
	// phase behind a pending transfer cannot overwrite it.
	always_ff @(posedge Hclk)
	begin
		if (!Hresetn)
		begin
			pipe.Hwritereg <= 1'b0;
		end
		else if (pipe.valid)
		begin
			pipe.Hwritereg <= Hwrite;
		end
	end

endmodule

/* hdl/apbFsmController.sv */
`timescale 1ns/1ps

module apbFsmController
	import bridgePkg::*;
(
	input logic Hclk,
	input logic Hresetn,
	ahbPipeIf.ctrl pipe,
	input logic [31:0] Haddr,
	input logic [31:0] Hwdata,
	input logic Hwrite,
	output logic Pwrite,
	output logic Penable,
	output logic [2:0] Pselx,
	output logic [31:0] Paddr,
	output logic [31:0] Pwdata,
	output logic Hreadyout
);

	apbState_t state;
	apbState_t nextState;

	logic [2:0] selx1;
	logic [2:0] selx2;
	logic fromPend;

	logic pwriteNext;
	logic penableNext;
	logic hreadyNext;
	logic [2:0] pselNext;
	logic [31:0] paddrNext;
	logic [31:0] pwdataNext;

	always_ff @(posedge Hclk)
	begin
		if (!Hresetn)
		begin
			state <= stIdle;
			fromPend <= 1'b0;
		end
		else
		begin
			state <= nextState;
			fromPend <= (state == stWenableP); // setup came from the pending slot.
		end
	end

	// selects follow the address pipeline.
	always_ff @(posedge Hclk)
	begin
		selx1 <= pipe.tempselx;
		selx2 <= selx1;
	end

	always_comb
	begin
		nextState = stIdle;
		case (state)
			stIdle, stRenable, stWenable:
			begin
				if (!pipe.valid)
					nextState = stIdle;
				else if (Hwrite)
					nextState = stWwait;
				else
					nextState = stRead;
			end
			stWwait:
			begin
				if (pipe.valid)
					nextState = stWriteP;
				else
					nextState = stWrite;
			end
			stRead:
			begin
				nextState = stRenable;
			end
			stWrite:
			begin
				if (pipe.valid)
					nextState = stWenableP;
				else
					nextState = stWenable;
			end
			stWriteP:
			begin
				nextState = stWenableP;
			end
			stWenableP:
			begin
				if (!pipe.Hwritereg)
					nextState = stRead;
				else if (pipe.valid)
					nextState = stWriteP;
				else
					nextState = stWrite;
			end
			default:
			begin
				nextState = stIdle;
			end
		endcase
	end

	// decode of the next bus cycle. payload holds unless a setup is launched.
	always_comb
	begin
		paddrNext = Paddr;
		pwriteNext = Pwrite;
		pwdataNext = Pwdata;
		pselNext = Pselx;
		penableNext = 1'b0;
		hreadyNext = 1'b0;
		case (state)
			stIdle, stRenable, stWenable:
			begin
				pselNext = selNone;
				hreadyNext = 1'b1;
				if (pipe.valid && !Hwrite)
				begin
					// read goes straight to setup.
					paddrNext = Haddr;
					pwriteNext = 1'b0;
					pselNext = pipe.tempselx;
					hreadyNext = 1'b0;
				end
			end
			stWwait:
			begin
				// data phase of the write is on the bus now.
				paddrNext = pipe.Haddr1;
				pwriteNext = 1'b1;
				pselNext = selx1;
				pwdataNext = Hwdata;
			end
			stRead:
			begin
				penableNext = 1'b1;
				hreadyNext = 1'b1; // Hrdata valid with Penable.
			end
			stWrite:
			begin
				penableNext = 1'b1;
				pwdataNext = fromPend ? pipe.Hwdata2 : pipe.Hwdata1;
				hreadyNext = 1'b1;
			end
			stWriteP:
			begin
				penableNext = 1'b1;
				pwdataNext = fromPend ? pipe.Hwdata2 : pipe.Hwdata1;
				// a pending read keeps its data phase stalled.
				hreadyNext = pipe.Hwritereg;
			end
			stWenableP:
			begin
				paddrNext = pipe.Haddr2;
				pwriteNext = pipe.Hwritereg;
				pselNext = selx2;
				pwdataNext = pipe.Hwdata1; // first cycle of its data phase.
			end
			default:
			begin
				pselNext = selNone;
			end
		endcase
	end

	always_ff @(posedge Hclk)
	begin
		if (!Hresetn)
		begin
			Paddr <= '0;
			Pwrite <= 1'b0;
			Pselx <= selNone;
			Pwdata <= '0;
			Penable <= 1'b0;
			Hreadyout <= 1'b0;
		end
		else
		begin
			Paddr <= paddrNext;
			Pwrite <= pwriteNext;
			Pselx <= pselNext;
			Pwdata <= pwdataNext;
			Penable <= penableNext;
			Hreadyout <= hreadyNext;
		end
	end

endmodule

/* hdl/ahbApbBridge.sv */
`timescale 1ns/1ps

module ahbApbBridge
	import bridgePkg::*;
(
	input logic Hclk,
	input logic Hresetn,
	input logic Hreadyin,
	input logic [1:0] Htrans,
	input logic Hwrite,
	input logic [31:0] Haddr,
	input logic [31:0] Hwdata,
	input logic [31:0] Prdata,
	output logic Pwrite,
	output logic Penable,
	output logic [2:0] Pselx,
	output logic [31:0] Paddr,
	output logic [31:0] Pwdata,
	output logic Hreadyout,
	output logic [31:0] Hrdata,
	output logic [1:0] Hresp
);

	ahbPipeIf pipe ();

	ahbSlaveFront front_i
	(
		.Hclk(Hclk),
		.Hresetn(Hresetn),
		.Hreadyin(Hreadyin),
		.Htrans(Htrans),
		.Hwrite(Hwrite),
		.Haddr(Haddr),
		.Hwdata(Hwdata),
		.pipe(pipe.front)
	);

	apbFsmController ctrl_i
	(
		.Hclk(Hclk),
		.Hresetn(Hresetn),
		.pipe(pipe.ctrl),
		.Haddr(Haddr),
		.Hwdata(Hwdata),
		.Hwrite(Hwrite),
		.Pwrite(Pwrite),
		.Penable(Penable),
		.Pselx(Pselx),
		.Paddr(Paddr),
		.Pwdata(Pwdata),
		.Hreadyout(Hreadyout)
	);

	assign Hrdata = Prdata; // read data passes through.
	assign Hresp = respOkay;

endmodule

/* tb/bridgeFsm_properties.sv */
`timescale 1ns/1ps

module bridgeFsm_properties
	import bridgePkg::*;
(
	input logic Hclk,
	input logic Hresetn,
	input apbState_t state,
	input logic Penable,
	input logic [2:0] Pselx,
	input logic [31:0] Paddr
);

	// enable follows a setup of the same transfer.
	enableAfterSetup: assert property (@(posedge Hclk) disable iff (!Hresetn)
		Penable |-> ($past(Pselx) != selNone) && !$past(Penable)
			&& (Pselx == $past(Pselx)) && (Paddr == $past(Paddr)))
	else
		$error("Penable high without a matching setup cycle");

	selOneHot: assert property (@(posedge Hclk) disable iff (!Hresetn) $onehot0(Pselx))
	else
		$error("Pselx is not one-hot");

	// Penable marks exactly the enable states.
	enableState: assert property (@(posedge Hclk) disable iff (!Hresetn)
		Penable == (state inside {stRenable, stWenable, stWenableP}))
	else
		$error("Penable out of step with the controller state");

endmodule

/* tb/bridgeTb.sv */
`timescale 1ns/1ps

module bridgeTb
	import bridgePkg::*;
();

	logic Hclk;
	logic Hresetn;
	logic Hreadyin;
	logic [1:0] Htrans;
	logic Hwrite;
	logic [31:0] Haddr;
	logic [31:0] Hwdata;
	logic [31:0] Prdata = 32'h0;
	logic Pwrite;
	logic Penable;
	logic [2:0] Pselx;
	logic [31:0] Paddr;
	logic [31:0] Pwdata;
	logic Hreadyout;
	logic [31:0] Hrdata;
	logic [1:0] Hresp;

	logic [64:0] expQ [$]; // {write, addr, data}.
	logic [31:0] slaveMem [logic [31:0]];
	logic [31:0] refMem [logic [31:0]];
	logic pendValid;
	logic pendWrite;
	logic [31:0] pendAddr;
	logic accepted;
	logic curWrite;
	logic [31:0] curData;
	logic timedOut;
	int checkErrors = 0;
	int flowErrors;
	int checkedCount = 0;
	int timeouts;

	ahbApbBridge dut_i
	(
		.Hclk(Hclk),
		.Hresetn(Hresetn),
		.Hreadyin(Hreadyin),
		.Htrans(Htrans),
		.Hwrite(Hwrite),
		.Haddr(Haddr),
		.Hwdata(Hwdata),
		.Prdata(Prdata),
		.Pwrite(Pwrite),
		.Penable(Penable),
		.Pselx(Pselx),
		.Paddr(Paddr),
		.Pwdata(Pwdata),
		.Hreadyout(Hreadyout),
		.Hrdata(Hrdata),
		.Hresp(Hresp)
	);

	bind apbFsmController bridgeFsm_properties props_i
	(
		.Hclk(Hclk),
		.Hresetn(Hresetn),
		.state(state),
		.Penable(Penable),
		.Pselx(Pselx),
		.Paddr(Paddr)
	);

	assign Hreadyin = Hreadyout; // single slave on the bus.

	initial Hclk = 1'b0;
	always #5 Hclk = ~Hclk;

	// each window spans 64 MB above its base.
	function automatic logic [2:0] windowSel(input logic [31:0] addr);
		logic [31:0] span;
		span = 32'd1 << (32 - windowBits);
		if (addr >= slaveBase0 && addr < slaveBase0 + span)
			return sel0;
		if (addr >= slaveBase1 && addr < slaveBase1 + span)
			return sel1;
		if (addr >= slaveBase2 && addr < slaveBase2 + span)
			return sel2;
		return selNone;
	endfunction

	function automatic logic [31:0] refWord(input logic [31:0] addr);
		if (refMem.exists(addr))
			return refMem[addr];
		return addr; // unwritten words read back their address.
	endfunction

	task automatic compareValue(input string name, input logic [31:0] got,
		input logic [31:0] want, inout int count);
		assert (got == want)
		else
		begin
			count++;
			$display("ERROR %0t: %s got %h expected %h", $time, name, got, want);
		end
	endtask

	task automatic scoreTransfer();
		logic [64:0] head;
		assert (expQ.size() != 0)
		else
		begin
			checkErrors++;
			$display("%0t: APB transfer to %h without an AHB request", $time, Paddr);
		end
		if (expQ.size() != 0)
		begin
			head = expQ.pop_front();
			checkedCount++;
			compareValue("Paddr", Paddr, head[63:32], checkErrors);
			compareValue("Pwrite", 32'(Pwrite), 32'(head[64]), checkErrors);
			compareValue("Pselx", 32'(Pselx), 32'(windowSel(head[63:32])), checkErrors);
			if (head[64])
			begin
				compareValue("Pwdata", Pwdata, head[31:0], checkErrors);
				refMem[head[63:32]] = head[31:0];
			end
			else
			begin
				compareValue("Hrdata", Hrdata, refWord(head[63:32]), checkErrors);
				compareValue("Hreadyout", 32'(Hreadyout), 32'd1, checkErrors);
			end
		end
	endtask

	// mode 0 random, 1 writes only, 2 idle.
	task automatic pickPhase(input int mode);
		logic [31:0] r;
		logic [31:0] base;
		r = $urandom;
		curData = $urandom;
		case (r[4:2])
			3'd0, 3'd1: base = slaveBase0;
			3'd2, 3'd3: base = slaveBase1;
			3'd7: base = r[10] ? 32'h8C00_0000 : 32'h7FFF_FF00; // just outside.
			default: base = slaveBase2;
		endcase
		if (mode == 1 && r[4:2] == 3'd7)
			base = slaveBase1;
		Haddr = base + {26'b0, r[8:5], 2'b00};
		Htrans = r[9] ? transSeq : transNonseq;
		if (mode == 2 || (mode == 0 && r[1:0] == 2'b00))
			Htrans = transIdle;
		curWrite = (mode == 1) || r[1];
		Hwrite = curWrite;
	endtask

	task automatic driveMaster(input int count, input int mode);
		int issued;
		int stall;
		issued = 0;
		stall = 0;
		while (issued < count && !timedOut)
		begin
			@(negedge Hclk);
			if (accepted)
			begin
				Hwdata = curWrite ? curData : $urandom; // data phase of the accepted one.
				pickPhase(mode);
				issued++;
			end
			accepted = Hreadyout;
			stall = accepted ? 0 : stall + 1;
			if (stall > 8)
			begin
				timedOut = 1'b1;
				timeouts++;
				$display("%0t: Hreadyout stayed low for more than 8 cycles", $time);
			end
		end
	endtask

	// APB slave memory.
	always @(negedge Hclk)
	begin
		if (Pselx != selNone && Penable && Pwrite)
			slaveMem[Paddr] = Pwdata;
		if (slaveMem.exists(Paddr))
			Prdata = slaveMem[Paddr];
		else
			Prdata = Paddr;
	end

	// scoreboard. a request is queued when its data phase completes.
	always @(posedge Hclk)
	begin
		if (!Hresetn)
			pendValid = 1'b0;
		else
		begin
			if (Hreadyout)
			begin
				compareValue("Hresp", 32'(Hresp), 32'd0, checkErrors); // OKAY.
				if (pendValid)
					expQ.push_back({pendWrite, pendAddr, Hwdata});
				pendValid = (Htrans == transNonseq || Htrans == transSeq)
					&& windowSel(Haddr) != selNone;
				pendWrite = Hwrite;
				pendAddr = Haddr;
			end
			if (Pselx != selNone && Penable)
				scoreTransfer();
		end
	end

	initial
	begin
		int waitCycles;
		void'($urandom(26));
		Hresetn = 1'b0;
		Htrans = transIdle;
		Hwrite = 1'b0;
		Haddr = 32'h0;
		Hwdata = 32'h0;
		accepted = 1'b0;
		curWrite = 1'b0;
		curData = 32'h0;
		timedOut = 1'b0;
		flowErrors = 0;
		timeouts = 0;
		repeat (10) @(posedge Hclk);
		@(negedge Hclk);
		compareValue("Pselx", 32'(Pselx), 32'(selNone), flowErrors);
		compareValue("Penable", 32'(Penable), 32'd0, flowErrors);
		compareValue("Hreadyout", 32'(Hreadyout), 32'd0, flowErrors);
		Hresetn = 1'b1;
		waitCycles = 0;
		while (!Hreadyout && waitCycles < 2)
		begin
			@(negedge Hclk);
			waitCycles++;
		end
		assert (Hreadyout)
		else
		begin
			flowErrors++;
			$display("%0t: Hreadyout did not rise within two cycles of reset", $time);
		end
		accepted = Hreadyout;
		driveMaster(300, 0);
		driveMaster(24, 1);
		driveMaster(3, 2);
		waitCycles = 0;
		while (expQ.size() != 0 && waitCycles < 20)
		begin
			@(negedge Hclk);
			waitCycles++;
		end
		assert (expQ.size() == 0)
		else
		begin
			timeouts++;
			$display("%0d expected APB transfers never appeared", expQ.size());
		end
		repeat (4) @(negedge Hclk); // catch stray transfers.
		$display("transfers %0d, check errors %0d, flow errors %0d, timeouts %0d",
			checkedCount, checkErrors, flowErrors, timeouts);
		if (checkErrors == 0 && flowErrors == 0 && timeouts == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

/* vlog.f */
hdl/bridgePkg.sv
hdl/ahbPipeIf.sv
hdl/ahbSlaveFront.sv
hdl/apbFsmController.sv
hdl/ahbApbBridge.sv
tb/bridgeFsm_properties.sv
tb/bridgeTb.sv

/* run.sh */
#!/bin/sh
# builds and runs the bridge testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f vlog.f --top-module bridgeTb -Mdir obj_dir -o bridgeSim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/bridgeSim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qx "Testbench passed" sim.log; then
	exit 0
fi
exit 1
